// ==== fetch_subsys.f ====
hw/icache_pkg.sv
hw/sram_sp.sv
hw/refill_buffer.sv
hw/icache.sv
hw/line_read_bridge.sv
hw/fetch_subsys.sv
tests/mem_model.sv
tests/tb_fetch_subsys.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the fetch subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_fetch_subsys \
    -f fetch_subsys.f \
    -o sim_fetch_subsys

./obj_dir/sim_fetch_subsys | tee sim.log

if grep -qx "All tests passed" sim.log; then
    echo "run.sh: simulation passed"
else
    echo "run.sh: simulation failed"
    exit 1
fi

// ==== tests/tb_fetch_subsys.sv ====
// tb_fetch_subsys: clock, reset, fetch stimulus, shadow tag model, checks, timeout and summary
`timescale 1ns/1ps

module tb_fetch_subsys;
    localparam int INDEX_BITS       = 8;
    localparam int TAG_BITS         = 32 - INDEX_BITS - icache_pkg::OFFSET_BITS;
    localparam int NUM_RANDOM       = 250;
    localparam int MAX_FETCH_CYCLES = 35;
    localparam int TIMEOUT_CYCLES   = (NUM_RANDOM + 50) * MAX_FETCH_CYCLES + 1500;
    localparam icache_pkg::word_t MEM_KEY = 32'h5A5A_0000;
    localparam icache_pkg::word_t ADDR_A  = 32'h0001_2340;
    localparam icache_pkg::word_t ADDR_B  = 32'h0004_5340;

    // one outstanding fetch as the testbench sees it
    typedef struct packed {
        logic              active;
        logic              miss;
        icache_pkg::word_t addr;
        logic [31:0]       accept_cycle;
        logic [7:0]        req_count;
    } pending_t;

    logic              clock;
    logic              reset;
    logic              valid;
    icache_pkg::word_t addr;
    logic              addr_ok;
    logic              data_ok;
    icache_pkg::line_t rdata;
    logic              mem_req;
    icache_pkg::word_t mem_addr;
    logic              mem_valid;
    icache_pkg::word_t mem_data;

    pending_t              pend;
    logic [31:0]           cycle;
    logic                  started;
    logic [TAG_BITS-1:0]   shadow_tag [1 << INDEX_BITS];
    logic                  shadow_valid [1 << INDEX_BITS];
    string                 test_name;
    int                    errors;
    int                    fetches;
    icache_pkg::word_t     rand_addr;

    fetch_subsys #(
        .INDEX_BITS (INDEX_BITS)
    ) DUT (
        .clock      (clock),
        .reset      (reset),
        .valid      (valid),
        .addr       (addr),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_valid  (mem_valid),
        .mem_data   (mem_data)
    );

    mem_model #(
        .KEY        (MEM_KEY)
    ) u_mem (
        .clock      (clock),
        .reset      (reset),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_valid  (mem_valid),
        .mem_data   (mem_data)
    );

    always #5 clock = ~clock;

    function automatic logic [INDEX_BITS-1:0] index_of(input icache_pkg::word_t a);
        return a[icache_pkg::OFFSET_BITS +: INDEX_BITS];
    endfunction

    function automatic logic [TAG_BITS-1:0] tag_of(input icache_pkg::word_t a);
        return a[31 -: TAG_BITS];
    endfunction

    // word at byte address a is a ^ key, lowest word on top
    function automatic icache_pkg::line_t expected_line(input icache_pkg::word_t a);
        icache_pkg::line_t line;
        icache_pkg::word_t base;
        base = {a[31:4], 4'h0};
        for (int i = 0; i < 4; i++) begin
            line[(3 - i) * 32 +: 32] = (base + 32'(4 * i)) ^ MEM_KEY;
        end
        return line;
    endfunction

    // ************************************************************
    // request tracking and shadow tags
    // ************************************************************

    always @(posedge clock) begin
        if (reset) begin
            cycle <= '0;
            pend  <= '0;
            for (int i = 0; i < (1 << INDEX_BITS); i++) begin
                shadow_valid[i] <= 1'b0;
            end
        end else begin
            cycle <= cycle + 32'd1;
            if (valid && addr_ok) begin
                pend.active       <= 1'b1;
                pend.addr         <= addr;
                pend.miss         <= !(shadow_valid[index_of(addr)] &&
                                       shadow_tag[index_of(addr)] == tag_of(addr));
                pend.accept_cycle <= cycle;
                pend.req_count    <= '0;
            end else if (mem_req) begin
                pend.req_count <= pend.req_count + 8'd1;
            end
            if (data_ok) begin
                pend.active                  <= 1'b0;
                shadow_valid[index_of(pend.addr)] <= 1'b1;
                shadow_tag[index_of(pend.addr)]   <= tag_of(pend.addr);
            end
        end
    end

    always @(posedge clock) begin
        if (cycle >= 32'(TIMEOUT_CYCLES)) begin
            $display("timeout: a fetch did not complete within %0d cycles", TIMEOUT_CYCLES);
            $display("fetches: %0d, errors: %0d", fetches, errors);
            $display("Some tests failed");
            $finish;
        end
    end

    // ************************************************************
    // checks
    // ************************************************************

    a_reset_idle: assert property (@(posedge clock) disable iff (reset)
        !started |-> addr_ok && !data_ok && !mem_req)
    else begin
        errors++;
        $display("[FAIL] after_reset: expected addr_ok/data_ok/mem_req 100, actual %b%b%b",
                 $sampled(addr_ok), $sampled(data_ok), $sampled(mem_req));
    end

    a_miss_only: assert property (@(posedge clock) disable iff (reset)
        mem_req |-> pend.active && pend.miss)
    else begin
        errors++;
        $display("[FAIL] %s: mem_req expected 0 on a predicted hit, actual 1", test_name);
    end

    a_mem_addr: assert property (@(posedge clock) disable iff (reset)
        mem_req |-> mem_addr == {pend.addr[31:4], 4'h0})
    else begin
        errors++;
        $display("[FAIL] %s: mem_addr expected %h, actual %h", test_name,
                 {$sampled(pend.addr[31:4]), 4'h0}, $sampled(mem_addr));
    end

    a_data_owned: assert property (@(posedge clock) disable iff (reset)
        data_ok |-> pend.active)
    else begin
        errors++;
        $display("data_ok came while no fetch was outstanding (%s)", test_name);
    end

    a_hit_miss: assert property (@(posedge clock) disable iff (reset)
        data_ok |-> pend.req_count == {7'd0, pend.miss})
    else begin
        errors++;
        $display("[FAIL] %s: mem_req count expected %0d, actual %0d", test_name,
                 $sampled(pend.miss), $sampled(pend.req_count));
    end

    a_line_data: assert property (@(posedge clock) disable iff (reset)
        data_ok |-> rdata == expected_line(pend.addr))
    else begin
        errors++;
        $display("[FAIL] %s: rdata expected %h, actual %h", test_name,
                 expected_line($sampled(pend.addr)), $sampled(rdata));
    end

    // hit pulse lands on the second edge after acceptance
    a_hit_latency: assert property (@(posedge clock) disable iff (reset)
        data_ok && !pend.miss |-> cycle == pend.accept_cycle + 32'd2)
    else begin
        errors++;
        $display("[FAIL] %s: hit data_ok at cycle expected %0d, actual %0d", test_name,
                 $sampled(pend.accept_cycle) + 32'd2, $sampled(cycle));
    end

    // ************************************************************
    // stimulus
    // ************************************************************

    task automatic fetch(input icache_pkg::word_t a, input string name);
        @(negedge clock);
        test_name = name;
        started   = 1'b1;
        valid     = 1'b1;
        addr      = a;
        while (!addr_ok) begin
            @(negedge clock);
        end
        @(negedge clock);
        valid = 1'b0;
        while (!data_ok) begin
            @(negedge clock);
        end
        fetches++;
    endtask

    initial begin
        void'($urandom(98));
        clock     = 1'b0;
        reset     = 1'b1;
        valid     = 1'b0;
        addr      = '0;
        started   = 1'b0;
        errors    = 0;
        fetches   = 0;
        test_name = "after_reset";
        repeat (8) @(negedge clock);
        reset = 1'b0;
        repeat (4) @(negedge clock);

        fetch(ADDR_A, "cold_miss");
        fetch(ADDR_A + 32'h8, "same_line_hit");
        fetch(ADDR_B, "conflict_miss");
        fetch(ADDR_A + 32'h4, "evicted_refetch_a");
        fetch(ADDR_B + 32'hC, "evicted_refetch_b");

        // 4 tags over 8 indices
        for (int n = 0; n < NUM_RANDOM; n++) begin
            rand_addr = ((32'h100 + ($urandom % 4)) << 12) | (($urandom % 8) << 4) |
                        (($urandom % 4) << 2);
            fetch(rand_addr, "random_fetch");
        end

        repeat (2) @(negedge clock);
        $display("fetches: %0d, errors: %0d", fetches, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== tests/mem_model.sv ====
// mem_model: external memory responder, four beats per line strobe with random delay and gaps
`timescale 1ns/1ps

module mem_model #(
    parameter icache_pkg::word_t KEY = 32'h5A5A_0000
) (
    input  logic              clock,
    input  logic              reset,
    input  logic              mem_req,
    input  icache_pkg::word_t mem_addr,
    output logic              mem_valid,
    output icache_pkg::word_t mem_data
);
    localparam int BEATS = icache_pkg::BEATS_PER_LINE;

    initial begin
        mem_valid = 1'b0;
        mem_data  = '0;
    end

    // beats go out on falling edges, in address order
    task automatic send_line(input icache_pkg::word_t base);
        int unsigned delay;
        int unsigned gap;
        delay = 1 + ($urandom % 6);
        repeat (delay) @(negedge clock);
        for (int i = 0; i < BEATS; i++) begin
            mem_valid = 1'b1;
            mem_data  = (base + 32'(4 * i)) ^ KEY;
            @(negedge clock);
            mem_valid = 1'b0;
            if (i < BEATS - 1) begin
                gap = $urandom % 4;
                repeat (gap) @(negedge clock);
            end
        end
    endtask

    // strobe is stable at the falling edge of its cycle
    always @(negedge clock) begin
        if (!reset && mem_req) begin
            send_line(mem_addr);
        end
    end

endmodule

// ==== hw/fetch_subsys.sv ====
// fetch_subsys: instruction cache joined to the line read bridge
`timescale 1ns/1ps

module fetch_subsys #(
    parameter int INDEX_BITS = 8
) (
    input  logic              clock,
    input  logic              reset,
    // cpu fetch port
    input  logic              valid,
    input  icache_pkg::word_t addr,
    output logic              addr_ok,
    output logic              data_ok,
    output icache_pkg::line_t rdata,
    // external memory
    output logic              mem_req,
    output icache_pkg::word_t mem_addr,
    input  logic              mem_valid,
    input  icache_pkg::word_t mem_data
);
    logic                  rd_req;
    logic                  rd_rdy;
    icache_pkg::rd_cmd_t   rd_cmd;
    logic                  ret_valid;
    icache_pkg::ret_beat_t ret_beat;

    icache #(
        .INDEX_BITS (INDEX_BITS)
    ) u_icache (
        .clock      (clock),
        .reset      (reset),
        .valid      (valid),
        .addr       (addr),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .rd_req     (rd_req),
        .rd_cmd     (rd_cmd),
        .rd_rdy     (rd_rdy),
        .ret_valid  (ret_valid),
        .ret_beat   (ret_beat)
    );

    line_read_bridge u_bridge (
        .clock      (clock),
        .reset      (reset),
        .rd_req     (rd_req),
        .rd_cmd     (rd_cmd),
        .rd_rdy     (rd_rdy),
        .ret_valid  (ret_valid),
        .ret_beat   (ret_beat),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_valid  (mem_valid),
        .mem_data   (mem_data)
    );

endmodule

// ==== hw/line_read_bridge.sv ====
// line_read_bridge: turns a line read into a memory strobe and forwards four beats
`timescale 1ns/1ps

module line_read_bridge (
    input  logic                  clock,
    input  logic                  reset,
    // cache side
    input  logic                  rd_req,
    input  icache_pkg::rd_cmd_t   rd_cmd,
    output logic                  rd_rdy,
    output logic                  ret_valid,
    output icache_pkg::ret_beat_t ret_beat,
    // external memory side
    output logic                  mem_req,
    output icache_pkg::word_t     mem_addr,
    input  logic                  mem_valid,
    input  icache_pkg::word_t     mem_data
);
    localparam int BEATS    = icache_pkg::BEATS_PER_LINE;
    localparam int CNT_BITS = $clog2(BEATS);
    localparam logic [CNT_BITS-1:0] LAST_BEAT = CNT_BITS'(BEATS - 1);

    icache_pkg::bridge_state_e state;
    logic [CNT_BITS-1:0]       beat_cnt;
    logic                      cmd_take;
    logic                      last_beat;

    assign rd_rdy   = (state == icache_pkg::bridge_idle);
    assign cmd_take = rd_req && rd_rdy;

    assign last_beat = (beat_cnt == LAST_BEAT);

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= icache_pkg::bridge_idle;
            beat_cnt <= '0;
        end else begin
            case (state)
                icache_pkg::bridge_idle: begin
                    if (cmd_take) begin
                        state    <= icache_pkg::bridge_wait_beats;
                        beat_cnt <= '0;
                    end
                end
                icache_pkg::bridge_wait_beats: begin
                    if (mem_valid) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (last_beat) begin
                            state <= icache_pkg::bridge_idle;
                        end
                    end
                end
                default: begin
                    state <= icache_pkg::bridge_idle;
                end
            endcase
        end
    end

    // one-cycle strobe right after the command edge
    always_ff @(posedge clock) begin
        if (reset) begin
            mem_req <= 1'b0;
        end else begin
            mem_req <= cmd_take;
        end
    end

    always_ff @(posedge clock) begin
        if (cmd_take) begin
            mem_addr <= rd_cmd.addr;
        end
    end

    // beats pass straight through
    assign ret_valid = mem_valid;
    assign ret_beat  = '{data: mem_data, last: last_beat};

    a_line_size_only: assert property (
        @(posedge clock) disable iff (reset)
        cmd_take |-> rd_cmd.rd_type == icache_pkg::rd_line
    );

    // memory answers only to an outstanding strobe
    a_no_beat_when_idle: assert property (
        @(posedge clock) disable iff (reset)
        mem_valid |-> state == icache_pkg::bridge_wait_beats
    );

endmodule

// ==== hw/icache.sv ====
// icache: direct-mapped instruction cache controller with tag/valid and data arrays
`timescale 1ns/1ps

module icache #(
    parameter int INDEX_BITS = 8
) (
    input  logic                  clock,
    input  logic                  reset,
    // cpu side
    input  logic                  valid,
    input  icache_pkg::word_t     addr,
    output logic                  addr_ok,
    output logic                  data_ok,
    output icache_pkg::line_t     rdata,
    // bridge side
    output logic                  rd_req,
    output icache_pkg::rd_cmd_t   rd_cmd,
    input  logic                  rd_rdy,
    input  logic                  ret_valid,
    input  icache_pkg::ret_beat_t ret_beat
);
    localparam int TAG_BITS = 32 - INDEX_BITS - icache_pkg::OFFSET_BITS;

    typedef struct packed {
        logic [TAG_BITS-1:0]   tag;
        logic [INDEX_BITS-1:0] index;
    } req_t;

    typedef struct packed {
        logic [TAG_BITS-1:0] tag;
        logic                valid;
    } tagv_t;

    icache_pkg::cache_state_e state;
    icache_pkg::cache_state_e state_next;

    req_t              req;
    tagv_t             tagv_rd;
    tagv_t             tagv_wr;
    logic              hit;

    logic                  tagv_en;
    logic                  tagv_we;
    logic [INDEX_BITS-1:0] tagv_addr;

    logic                  data_en;
    logic                  data_we;
    icache_pkg::line_t     data_rd;

    logic                  refill_start;
    logic                  refill_beat;
    logic                  refill_done;
    icache_pkg::line_t     refill_line;

    // ********************************************************
    // request buffer and tag compare
    // ********************************************************

    always_ff @(posedge clock) begin
        if (valid && addr_ok) begin
            req.tag   <= addr[31 -: TAG_BITS];
            req.index <= addr[icache_pkg::OFFSET_BITS +: INDEX_BITS];
        end
    end

    assign hit = tagv_rd.valid && (tagv_rd.tag == req.tag);

    // ********************************************************
    // arrays
    // ********************************************************

    // tag read at accept, tag write on refill
    assign tagv_en   = (state == icache_pkg::cache_idle && valid) || tagv_we;
    assign tagv_we   = (state == icache_pkg::cache_refill_wb);
    assign tagv_addr = tagv_we ? req.index : addr[icache_pkg::OFFSET_BITS +: INDEX_BITS];
    assign tagv_wr   = '{tag: req.tag, valid: 1'b1};

    assign data_we = (state == icache_pkg::cache_refill_wb);
    assign data_en = (state == icache_pkg::cache_lookup && hit) || data_we;

    sram_sp #(
        .ADDR_BITS  (INDEX_BITS),
        .DATA_BITS  (TAG_BITS + 1)
    ) u_tagv_sram (
        .clock      (clock),
        .reset      (reset),
        .enable     (tagv_en),
        .write_en   (tagv_we),
        .address    (tagv_addr),
        .write_data (tagv_wr),
        .read_data  (tagv_rd)
    );

    sram_sp #(
        .ADDR_BITS  (INDEX_BITS),
        .DATA_BITS  ($bits(icache_pkg::line_t))
    ) u_data_sram (
        .clock      (clock),
        .reset      (reset),
        .enable     (data_en),
        .write_en   (data_we),
        .address    (req.index),
        .write_data (refill_line),
        .read_data  (data_rd)
    );

    assign refill_start = (state == icache_pkg::cache_request);
    assign refill_beat  = (state == icache_pkg::cache_receive) && ret_valid;

    refill_buffer u_refill (
        .clock      (clock),
        .reset      (reset),
        .start      (refill_start),
        .beat_valid (refill_beat),
        .beat       (ret_beat),
        .line       (refill_line),
        .complete   (refill_done)
    );

    // ********************************************************
    // control FSM
    // ********************************************************

    always_comb begin
        state_next = state;
        case (state)
            icache_pkg::cache_idle: begin
                if (valid) begin
                    state_next = icache_pkg::cache_lookup;
                end
            end
            icache_pkg::cache_lookup: begin
                state_next = hit ? icache_pkg::cache_hit_out : icache_pkg::cache_request;
            end
            icache_pkg::cache_hit_out: begin
                state_next = icache_pkg::cache_idle;
            end
            icache_pkg::cache_request: begin
                if (rd_rdy) begin
                    state_next = icache_pkg::cache_receive;
                end
            end
            icache_pkg::cache_receive: begin
                if (refill_done) begin
                    state_next = icache_pkg::cache_refill_wb;
                end
            end
            default: begin
                state_next = icache_pkg::cache_idle;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= icache_pkg::cache_idle;
        end else begin
            state <= state_next;
        end
    end

    // outputs
    assign addr_ok = (state == icache_pkg::cache_idle);
    assign data_ok = (state == icache_pkg::cache_hit_out) || (state == icache_pkg::cache_refill_wb);
    assign rdata   = (state == icache_pkg::cache_refill_wb) ? refill_line : data_rd;

    assign rd_req = (state == icache_pkg::cache_request);
    assign rd_cmd = '{
        rd_type: icache_pkg::rd_line,
        addr:    {req.tag, req.index, {icache_pkg::OFFSET_BITS{1'b0}}}
    };

    // every returned beat must land in the refill buffer
    a_beat_in_receive: assert property (
        @(posedge clock) disable iff (reset)
        ret_valid |-> state == icache_pkg::cache_receive
    );

    // cpu may only raise valid when idle or on the data_ok cycle
    a_valid_protocol: assert property (
        @(posedge clock) disable iff (reset)
        $rose(valid) |-> addr_ok || data_ok
    );

endmodule

// ==== hw/refill_buffer.sv ====
// refill_buffer: gathers the returned beats of one line and flags the completing beat
`timescale 1ns/1ps

module refill_buffer (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  start,
    input  logic                  beat_valid,
    input  icache_pkg::ret_beat_t beat,
    output icache_pkg::line_t     line,
    output logic                  complete
);
    localparam int BEATS    = icache_pkg::BEATS_PER_LINE;
    localparam int CNT_BITS = $clog2(BEATS);
    localparam logic [CNT_BITS-1:0] LAST_SLOT = CNT_BITS'(BEATS - 1);

    logic [CNT_BITS-1:0] count;
    icache_pkg::word_t   words [BEATS];

    // last flag or a full counter, whichever comes
    assign complete = beat_valid && (beat.last || count == LAST_SLOT);

    always_ff @(posedge clock) begin
        if (reset) begin
            count <= '0;
        end else if (start) begin
            count <= '0;
        end else if (beat_valid) begin
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (beat_valid) begin
            words[count] <= beat.data;
        end
    end

    // first beat ends up in the top word
    always_comb begin
        line = '0;
        for (int i = 0; i < BEATS; i++) begin
            line[(BEATS - 1 - i) * 32 +: 32] = words[i];
        end
    end

    // bridge counter and ours must stay in step
    a_last_matches_count: assert property (
        @(posedge clock) disable iff (reset)
        beat_valid |-> (beat.last == (count == LAST_SLOT))
    );

endmodule

// ==== hw/sram_sp.sv ====
// sram_sp: single-port synchronous SRAM with registered read data, cleared on reset
`timescale 1ns/1ps

module sram_sp #(
    parameter int ADDR_BITS = 8,
    parameter int DATA_BITS = 32
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 enable,
    input  logic                 write_en,
    input  logic [ADDR_BITS-1:0] address,
    input  logic [DATA_BITS-1:0] write_data,
    output logic [DATA_BITS-1:0] read_data
);
    localparam int DEPTH = 1 << ADDR_BITS;

    logic [DATA_BITS-1:0] mem [DEPTH];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
            read_data <= '0;
        end else if (enable) begin
            if (write_en) begin
                mem[address] <= write_data;
            end else begin
                read_data <= mem[address];
            end
        end
    end

    // the owner must be back in its rest state once reset has been seen
    a_no_write_after_reset: assert property (@(posedge clock) reset |=> !write_en);

endmodule

// ==== hw/icache_pkg.sv ====
// icache_pkg: line geometry, read sizes, bridge transfer structs and FSM states
package icache_pkg;

    // line geometry
    localparam int OFFSET_BITS    = 4;
    localparam int BEATS_PER_LINE = 4;

    typedef logic [31:0] word_t;

    // lowest-address word sits in bits 127:96
    typedef logic [127:0] line_t;

    // read sizes as seen by the bridge
    typedef enum logic [2:0] {
        rd_byte = 3'b000,
        rd_half = 3'b001,
        rd_word = 3'b010,
        rd_line = 3'b100
    } rd_type_e;

    // cache to bridge, address is line aligned
    typedef struct packed {
        rd_type_e rd_type;
        word_t    addr;
    } rd_cmd_t;

    // bridge to cache, one beat per ret_valid
    typedef struct packed {
        word_t data;
        logic  last;
    } ret_beat_t;

    typedef enum logic [2:0] {
        cache_idle,
        cache_lookup,
        cache_hit_out,
        cache_request,
        cache_receive,
        cache_refill_wb
    } cache_state_e;

    typedef enum logic {
        bridge_idle,
        bridge_wait_beats
    } bridge_state_e;

endpackage
